/* eighty_twos.f */
logic/eighty_twos_pkg.sv
logic/alu.sv
logic/reg_file.sv
logic/instr_decoder.sv
logic/program_counter.sv
logic/cycle_sequencer.sv
logic/eighty_twos.sv
testbench/eighty_twos_tb.sv

/* Makefile */
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG) for the pass line"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module eighty_twos_tb \
		-Mdir obj_dir -f eighty_twos.f
	./obj_dir/Veighty_twos_tb 2>&1 | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* testbench/eighty_twos_tb.sv */
`timescale 1ns/10ps
module eighty_twos_tb;

  localparam int addr_width     = 16;
  localparam int num_programs   = 10;
  localparam int max_instrs     = 60;
  localparam int timeout_cycles = num_programs * max_instrs * 8 * 4;  // x4 for cs stalls
  localparam int ev_rom = 0;  // Expected bus cycle kinds
  localparam int ev_rd  = 1;
  localparam int ev_wr  = 2;

  logic                  clk    = 1'b0;
  logic                  rst_n  = 1'b0;
  logic                  cs     = 1'b1;
  logic [7:0]            bus_in = 8'h00;
  logic [addr_width-1:0] addr;
  logic [7:0]            data_out;
  logic                  rom_rd;
  logic                  ram_rd;
  logic                  ram_wr;
  logic [7:0]            acc_out;
  logic                  halted;

  integer seed        = 66503;
  int     cycle_count = 0;
  int     stall_left  = 0;
  logic   stall_en    = 1'b0;

  logic [7:0]            rom [0:255];
  logic [7:0]            ram [0:255];
  logic [7:0]            mram [0:255];  // Model view of RAM
  logic [7:0]            m_reg [0:7];   // B..L at 0..5, A at 7
  logic [7:0]            m_flags;       // S Z - - - P - CY
  int                    exp_kind [$];
  logic [addr_width-1:0] exp_addr [$];
  logic [7:0]            exp_data [$];
  int                    ev_kind;
  logic [addr_width-1:0] ev_addr;
  logic [7:0]            ev_data;

  eighty_twos #(.addr_width(addr_width)) eighty_twos_inst (
    .clk(clk), .rst_n(rst_n), .cs(cs), .bus_in(bus_in), .addr(addr),
    .data_out(data_out), .rom_rd(rom_rd), .ram_rd(ram_rd), .ram_wr(ram_wr),
    .acc_out(acc_out), .halted(halted)
  );

  always #2 clk = ~clk;

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("TEST RESULT: FAIL");
    $fatal(1, "Simulation stopped at the first failure");
  endtask

  task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp) begin
      fail_run($sformatf("** Error: %s is 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_addr(input string name, input logic [addr_width-1:0] got,
                            input logic [addr_width-1:0] exp);
    if (got !== exp) begin
      fail_run($sformatf("** Error: %s is 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      fail_run($sformatf("** Error: %s is 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  // Length from the first byte, per the opcode table
  function automatic int instr_len(input logic [7:0] b0);
    if (b0 == 8'h3a || b0 == 8'h32 || b0 == 8'hc3) return 3;
    if (b0[7:6] == 2'b11 && b0[2:0] == 3'b010) return 3;
    if (b0[2:0] == 3'b110 && (b0[7:6] == 2'b00 || b0[7:6] == 2'b11)) return 2;
    return 1;
  endfunction

  function automatic logic cond_true(input logic [2:0] cc, input logic [7:0] f);
    case (cc)
      3'd0:    return !f[6];  // NZ
      3'd1:    return f[6];
      3'd2:    return !f[0];  // NC
      3'd3:    return f[0];
      3'd4:    return !f[2];  // PO
      3'd5:    return f[2];
      3'd6:    return !f[7];  // P
      default: return f[7];
    endcase
  endfunction

  function automatic logic [7:0] read_reg(input logic [2:0] r);
    return (r == 3'd6) ? 8'h00 : m_reg[r];
  endfunction

  task automatic write_reg(input logic [2:0] r, input logic [7:0] v);
    if (r != 3'd6) begin
      m_reg[r] = v;
    end
  endtask

  task automatic model_alu(input logic [2:0] func, input logic [7:0] b);
    int         ai;
    int         bi;
    int         ci;
    int         full;
    logic [7:0] res;
    logic       cy;
    ai = m_reg[7];
    bi = b;
    ci = m_flags[0];
    case (func)
      3'd0:    full = ai + bi;
      3'd1:    full = ai + bi + ci;
      3'd3:    full = ai - bi - ci;
      3'd4:    full = ai & bi;
      3'd5:    full = ai ^ bi;
      3'd6:    full = ai | bi;
      default: full = ai - bi;  // SUB and CMP
    endcase
    res     = 8'(full);
    cy      = (full < 0) || (full > 255);  // Borrow or carry out of 8 bits
    m_flags = {res[7], res == 8'h00, 3'b000, ($countones(res) % 2) == 0, 1'b0, cy};
    if (func != 3'd7) begin
      m_reg[7] = res;
    end
  endtask

  task automatic push_event(input int kind, input logic [addr_width-1:0] a, input logic [7:0] d);
    exp_kind.push_back(kind);
    exp_addr.push_back(a);
    exp_data.push_back(d);
  endtask

  // Random program ending in HLT with forward jumps to instruction starts
  task automatic gen_program();
    int                           n;
    int                           pos;
    int                           j;
    int                           kind [0:max_instrs-1];
    int                           start [0:max_instrs-1];
    eighty_twos_pkg::opcode_byte_u ob;
    n   = 40 + int'($unsigned($random(seed)) % 21);
    pos = 0;
    for (int i = 0; i < 256; i++) begin
      rom[i] = 8'(i);
      ram[i] = 8'($random(seed));
    end
    for (int i = 0; i < n; i++) begin
      kind[i]  = (i == n - 1) ? 9 : int'($unsigned($random(seed)) % 9);
      start[i] = pos;
      pos += (kind[i] inside {1, 3}) ? 2 : (kind[i] inside {4, 5, 6, 7}) ? 3 : 1;
    end
    for (int i = 0; i < n; i++) begin
      pos          = start[i];
      ob           = 8'h00;  // NOP
      rom[pos + 1] = 8'($random(seed));  // Immediate or direct address
      rom[pos + 2] = 8'h00;
      case (kind[i])
        0: begin
          ob.reg_v = {eighty_twos_pkg::cls_mov, 3'($random(seed)), 3'($random(seed))};
          if (ob == eighty_twos_pkg::op_hlt) begin
            ob.reg_v.src = eighty_twos_pkg::reg_a;
          end
        end
        1: ob.reg_v = {eighty_twos_pkg::cls_misc, 3'($random(seed)), eighty_twos_pkg::kind_imm};
        2: ob.reg_v = {eighty_twos_pkg::cls_alu, 3'($random(seed)), 3'($random(seed))};
        3: ob.op_v  = {eighty_twos_pkg::cls_imm, 3'($random(seed)), eighty_twos_pkg::kind_imm};
        4: ob = eighty_twos_pkg::op_lda;
        5: ob = eighty_twos_pkg::op_sta;
        6: ob = eighty_twos_pkg::op_jmp;
        7: ob.op_v  = {eighty_twos_pkg::cls_imm, 3'($random(seed)), eighty_twos_pkg::kind_jcc};
        9: ob = eighty_twos_pkg::op_hlt;
        default: ob = 8'h00;
      endcase
      if (kind[i] == 6 || kind[i] == 7) begin
        j            = i + 1 + int'($unsigned($random(seed)) % (n - 1 - i));
        rom[pos + 1] = 8'(start[j]);
      end
      rom[pos] = ob;
    end
  endtask

  // ISA model that fills the ordered list of expected bus cycles
  task automatic run_model();
    int          pc;
    int          len;
    logic [7:0]  b0;
    logic [7:0]  b1;
    logic [15:0] ta;
    bit          done;
    pc      = 0;
    done    = 1'b0;
    m_flags = 8'h00;
    exp_kind.delete();
    exp_addr.delete();
    exp_data.delete();
    for (int i = 0; i < 8; i++) begin
      m_reg[i] = 8'h00;
    end
    for (int i = 0; i < 256; i++) begin
      mram[i] = ram[i];
    end
    while (!done) begin
      b0  = rom[pc];
      b1  = rom[pc + 1];
      ta  = {rom[pc + 2], b1};
      len = instr_len(b0);
      for (int k = 0; k < len; k++) begin
        push_event(ev_rom, addr_width'(pc + k), 8'h00);
      end
      pc += len;
      if (b0 == 8'h76) begin
        done = 1'b1;
      end else begin
        case (b0[7:6])
          2'b01: write_reg(b0[5:3], read_reg(b0[2:0]));
          2'b10: model_alu(b0[5:3], read_reg(b0[2:0]));
          2'b00: begin
            if (b0[2:0] == 3'b110) begin
              write_reg(b0[5:3], b1);  // MVI
            end else if (b0 == 8'h3a) begin
              push_event(ev_rd, addr_width'(ta), 8'h00);
              m_reg[7] = mram[ta[7:0]];
            end else if (b0 == 8'h32) begin
              push_event(ev_wr, addr_width'(ta), m_reg[7]);
              mram[ta[7:0]] = m_reg[7];
            end
          end
          default: begin
            if (b0[2:0] == 3'b110) begin
              model_alu(b0[5:3], b1);
            end else if (b0 == 8'hc3 || (b0[2:0] == 3'b010 && cond_true(b0[5:3], m_flags))) begin
              pc = ta;
            end
          end
        endcase
      end
    end
  endtask

  always @(posedge clk) begin  // ROM and RAM answer one cycle after the strobe
    if (rom_rd) begin
      bus_in <= rom[addr[7:0]];
    end else if (ram_rd) begin
      bus_in <= ram[addr[7:0]];
    end
    if (ram_wr) begin
      ram[addr[7:0]] = data_out;
    end
  end

  always @(posedge clk) begin  // Random cs drops of 0 to 3 cycles
    if (stall_left > 0) begin
      cs         <= 1'b0;
      stall_left <= stall_left - 1;
    end else begin
      cs <= 1'b1;
      if (stall_en && $unsigned($random(seed)) % 5 == 0) begin
        stall_left <= int'($unsigned($random(seed)) % 4);
      end
    end
  end

  always @(posedge clk) begin  // Every strobe against the next expected bus cycle
    if (rst_n && (rom_rd || ram_rd || ram_wr)) begin
      if (!cs) begin
        fail_run("A bus strobe was issued while cs was low");
      end else if (exp_kind.size() == 0) begin
        fail_run("A bus strobe was issued after the last expected bus cycle");
      end else begin
        ev_kind = exp_kind.pop_front();
        ev_addr = exp_addr.pop_front();
        ev_data = exp_data.pop_front();
        check_bit("rom_rd", rom_rd, ev_kind == ev_rom);
        check_bit("ram_rd", ram_rd, ev_kind == ev_rd);
        check_bit("ram_wr", ram_wr, ev_kind == ev_wr);
        check_addr("addr", addr, ev_addr);
        if (ram_wr) begin
          check_byte("data_out", data_out, ev_data);
        end
      end
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > timeout_cycles) begin
      fail_run($sformatf("Timeout: core did not halt within %0d cycles", timeout_cycles));
    end
  end

  initial begin
    for (int p = 0; p < num_programs; p++) begin
      @(negedge clk);
      stall_en = (p >= num_programs / 2);  // Second half runs with stalls
      gen_program();
      run_model();
      @(posedge clk);
      rst_n <= 1'b0;
      repeat (2) @(posedge clk);
      rst_n <= 1'b1;
      check_bit("rom_rd", rom_rd, 1'b0);
      check_bit("ram_rd", ram_rd, 1'b0);
      check_bit("ram_wr", ram_wr, 1'b0);
      check_bit("halted", halted, 1'b0);
      while (halted !== 1'b1) begin
        @(posedge clk);
      end
      if (exp_kind.size() != 0) begin
        fail_run($sformatf("Core halted with %0d expected bus cycles missing", exp_kind.size()));
      end
      check_byte("acc_out", acc_out, m_reg[7]);
      repeat (8) @(posedge clk);  // Halt must stay silent on the bus
      check_bit("halted", halted, 1'b1);
    end
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

/* logic/eighty_twos.sv */
`timescale 1ns/10ps
module eighty_twos #(
  parameter int addr_width = 16
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  cs,       // Low stalls the core
  input  logic [7:0]            bus_in,   // ROM and RAM read data
  output logic [addr_width-1:0] addr,
  output logic [7:0]            data_out,
  output logic                  rom_rd,
  output logic                  ram_rd,
  output logic                  ram_wr,
  output logic [7:0]            acc_out,
  output logic                  halted
);

  logic [addr_width-1:0]    pc;
  logic [1:0]               num_bytes;
  logic                     is_load;
  logic                     is_store;
  logic                     is_jump;
  logic                     is_halt;
  logic                     jump_taken;
  logic [23:0]              instr;
  logic                     pc_inc;
  logic                     pc_load;
  logic                     exec;
  logic                     load_done;
  logic [7:0]               load_data;
  logic [2:0]               read_addr;
  logic [2:0]               write_addr;
  logic                     write_en_req;
  eighty_twos_pkg::alu_op_e op;
  logic                     use_imm;
  logic                     pass_src;
  eighty_twos_pkg::cond_e   cond;
  logic                     uncond;
  logic                     flag_write_req;
  logic [7:0]               immediate;
  logic [15:0]              target;
  logic [7:0]               read_data;
  logic [7:0]               flags;
  logic [7:0]               result;
  logic [7:0]               new_flags;

  cycle_sequencer #(.addr_width(addr_width)) cycle_sequencer_inst (
    .clk(clk), .rst_n(rst_n), .cs(cs), .bus_in(bus_in), .pc(pc),
    .num_bytes(num_bytes), .is_load(is_load), .is_store(is_store),
    .is_jump(is_jump), .is_halt(is_halt), .jump_taken(jump_taken), .acc(acc_out),
    .addr(addr), .data_out(data_out), .rom_rd(rom_rd), .ram_rd(ram_rd),
    .ram_wr(ram_wr), .instr(instr), .pc_inc(pc_inc), .pc_load(pc_load),
    .exec(exec), .load_done(load_done), .load_data(load_data), .halted(halted)
  );

  program_counter #(.addr_width(addr_width)) program_counter_inst (
    .clk(clk), .rst_n(rst_n), .pc_inc(pc_inc), .pc_load(pc_load),
    .target(target[addr_width-1:0]), .pc(pc)  // Narrow cores drop high address bits
  );

  instr_decoder instr_decoder_inst (
    .instr(instr), .num_bytes(num_bytes), .is_load(is_load), .is_store(is_store),
    .is_jump(is_jump), .is_halt(is_halt), .read_addr(read_addr),
    .write_addr(write_addr), .write_en_req(write_en_req), .op(op),
    .use_imm(use_imm), .pass_src(pass_src), .cond(cond), .uncond(uncond),
    .flag_write_req(flag_write_req), .immediate(immediate), .target(target)
  );

  reg_file reg_file_inst (
    .clk(clk), .rst_n(rst_n), .exec(exec), .read_addr(read_addr),
    .write_addr(write_addr), .write_en_req(write_en_req), .write_data(result),
    .load_done(load_done), .load_data(load_data), .flag_write_req(flag_write_req),
    .new_flags(new_flags), .read_data(read_data), .acc(acc_out), .flags(flags)
  );

  alu alu_inst (
    .op(op), .a(acc_out), .b(read_data), .immediate(immediate), .use_imm(use_imm),
    .pass_src(pass_src), .flags(flags), .cond(cond), .uncond(uncond),
    .result(result), .new_flags(new_flags), .jump_taken(jump_taken)
  );

endmodule

/* logic/cycle_sequencer.sv */
`timescale 1ns/10ps
module cycle_sequencer #(
  parameter int addr_width = 16
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  cs,
  input  logic [7:0]            bus_in,
  input  logic [addr_width-1:0] pc,
  input  logic [1:0]            num_bytes,
  input  logic                  is_load,
  input  logic                  is_store,
  input  logic                  is_jump,
  input  logic                  is_halt,
  input  logic                  jump_taken,
  input  logic [7:0]            acc,
  output logic [addr_width-1:0] addr,
  output logic [7:0]            data_out,
  output logic                  rom_rd,
  output logic                  ram_rd,
  output logic                  ram_wr,
  output logic [23:0]           instr,
  output logic                  pc_inc,
  output logic                  pc_load,
  output logic                  exec,
  output logic                  load_done,
  output logic [7:0]            load_data,
  output logic                  halted
);

  localparam logic [2:0] st_idle          = 3'd0;
  localparam logic [2:0] st_fetch_issue   = 3'd1;
  localparam logic [2:0] st_fetch_capture = 3'd2;
  localparam logic [2:0] st_execute       = 3'd3;
  localparam logic [2:0] st_mem_issue     = 3'd4;
  localparam logic [2:0] st_mem_capture   = 3'd5;
  localparam logic [2:0] st_halt          = 3'd6;

  logic [2:0]  state;
  logic [2:0]  state_next;
  logic [1:0]  byte_cnt;
  logic [23:0] instr_buf;
  logic        first_byte;

  // Byte 0 goes to the decoder while it is captured, so length is known in time
  assign first_byte = (state == st_fetch_capture) && (byte_cnt == 2'd0);
  assign instr      = {instr_buf[23:8], first_byte ? bus_in : instr_buf[7:0]};

  assign rom_rd    = cs && (state == st_fetch_issue);
  assign ram_rd    = cs && (state == st_mem_issue) && is_load;
  assign ram_wr    = cs && (state == st_mem_issue) && is_store;
  assign pc_inc    = cs && (state == st_fetch_capture);
  assign exec      = cs && (state == st_execute);
  assign pc_load   = exec && is_jump && jump_taken;
  assign load_done = cs && (state == st_mem_capture);
  assign load_data = bus_in;
  assign halted    = (state == st_halt);
  assign data_out  = acc;  // Only STA writes, always from A
  assign addr      = (state == st_mem_issue) ? instr_buf[8 +: addr_width] : pc;

  always_comb begin
    state_next = state;
    if (cs) begin  // Low cs freezes everything
      case (state)
        st_idle:          state_next = st_fetch_issue;
        st_fetch_issue:   state_next = st_fetch_capture;
        st_fetch_capture: state_next = (byte_cnt + 2'd1 == num_bytes) ? st_execute
                                                                      : st_fetch_issue;
        st_execute: begin
          if (is_halt) begin
            state_next = st_halt;
          end else if (is_load || is_store) begin
            state_next = st_mem_issue;
          end else begin
            state_next = st_fetch_issue;
          end
        end
        st_mem_issue:     state_next = is_load ? st_mem_capture : st_fetch_issue;
        st_mem_capture:   state_next = st_fetch_issue;
        st_halt:          state_next = st_halt;  // Left only by reset
        default:          state_next = st_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state    <= st_idle;
      byte_cnt <= 2'd0;
    end else begin
      state <= state_next;
      if (exec) begin
        byte_cnt <= 2'd0;  // Next instruction starts at byte 0
      end else if (pc_inc) begin
        byte_cnt <= byte_cnt + 2'd1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (pc_inc) begin
      instr_buf[{byte_cnt, 3'b000} +: 8] <= bus_in;
    end
  end

  a_strobe_onehot: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0({rom_rd, ram_rd, ram_wr}));

  // Stalled cycles leave state and byte count untouched
  a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
    !cs |=> (state == $past(state)) && (byte_cnt == $past(byte_cnt)));

  // Halt is sticky and silent on the bus
  a_halt_sticky: assert property (@(posedge clk) disable iff (!rst_n)
    halted |=> halted && !(rom_rd || ram_rd || ram_wr));

endmodule

/* logic/program_counter.sv */
`timescale 1ns/10ps
module program_counter #(
  parameter int addr_width = 16
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  pc_inc,
  input  logic                  pc_load,
  input  logic [addr_width-1:0] target,
  output logic [addr_width-1:0] pc
);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc <= '0;
    end else if (pc_load) begin
      pc <= target;  // Taken jump
    end else if (pc_inc) begin
      pc <= pc + 1'b1;  // One step per captured byte
    end
  end

  // Loads happen in execute, increments only in fetch
  a_inc_load_excl: assert property (@(posedge clk) disable iff (!rst_n)
    !(pc_inc && pc_load));

endmodule

/* logic/instr_decoder.sv */
`timescale 1ns/10ps
module instr_decoder (
  input  logic [23:0]               instr,
  output logic [1:0]                num_bytes,
  output logic                      is_load,
  output logic                      is_store,
  output logic                      is_jump,
  output logic                      is_halt,
  output logic [2:0]                read_addr,
  output logic [2:0]                write_addr,
  output logic                      write_en_req,
  output eighty_twos_pkg::alu_op_e  op,
  output logic                      use_imm,
  output logic                      pass_src,
  output eighty_twos_pkg::cond_e    cond,
  output logic                      uncond,
  output logic                      flag_write_req,
  output logic [7:0]                immediate,
  output logic [15:0]               target
);

  eighty_twos_pkg::opcode_byte_u b0;

  assign b0        = instr[7:0];
  assign immediate = instr[15:8];
  assign target    = instr[23:8];  // Low address byte comes first

  always_comb begin
    num_bytes      = 2'd1;  // Unknown bytes run as 1-byte NOP
    is_load        = 1'b0;
    is_store       = 1'b0;
    is_jump        = 1'b0;
    is_halt        = 1'b0;
    read_addr      = b0.reg_v.src;
    write_addr     = b0.reg_v.dst;
    write_en_req   = 1'b0;
    op             = eighty_twos_pkg::alu_op_e'(b0.op_v.func);
    cond           = eighty_twos_pkg::cond_e'(b0.op_v.func);
    use_imm        = 1'b0;
    pass_src       = 1'b0;
    uncond         = 1'b0;
    flag_write_req = 1'b0;

    case (b0.reg_v.cls)
      eighty_twos_pkg::cls_mov: begin
        if (b0 == eighty_twos_pkg::op_hlt) begin
          is_halt = 1'b1;  // Would be MOV M,M
        end else begin
          write_en_req = 1'b1;
          pass_src     = 1'b1;
        end
      end
      eighty_twos_pkg::cls_alu: begin
        write_addr     = eighty_twos_pkg::reg_a;
        write_en_req   = (op != eighty_twos_pkg::alu_cmp);  // CMP only sets flags
        flag_write_req = 1'b1;
      end
      eighty_twos_pkg::cls_misc: begin
        if (b0.reg_v.src == eighty_twos_pkg::kind_imm) begin
          num_bytes    = 2'd2;  // MVI
          use_imm      = 1'b1;
          pass_src     = 1'b1;
          write_en_req = 1'b1;
        end else if (b0 == eighty_twos_pkg::op_lda) begin
          num_bytes = 2'd3;
          is_load   = 1'b1;
        end else if (b0 == eighty_twos_pkg::op_sta) begin
          num_bytes = 2'd3;
          is_store  = 1'b1;
        end
      end
      default: begin  // Immediate class
        if (b0.op_v.kind == eighty_twos_pkg::kind_imm) begin
          num_bytes      = 2'd2;
          use_imm        = 1'b1;
          write_addr     = eighty_twos_pkg::reg_a;
          write_en_req   = (op != eighty_twos_pkg::alu_cmp);
          flag_write_req = 1'b1;
        end else if (b0 == eighty_twos_pkg::op_jmp) begin
          num_bytes = 2'd3;
          is_jump   = 1'b1;
          uncond    = 1'b1;
        end else if (b0.op_v.kind == eighty_twos_pkg::kind_jcc) begin
          num_bytes = 2'd3;
          is_jump   = 1'b1;
        end
      end
    endcase
  end

endmodule

/* logic/reg_file.sv */
`timescale 1ns/10ps
module reg_file (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       exec,
  input  logic [2:0] read_addr,
  input  logic [2:0] write_addr,
  input  logic       write_en_req,
  input  logic [7:0] write_data,
  input  logic       load_done,
  input  logic [7:0] load_data,
  input  logic       flag_write_req,
  input  logic [7:0] new_flags,
  output logic [7:0] read_data,
  output logic [7:0] acc,
  output logic [7:0] flags
);

  localparam logic [7:0] flag_mask = 8'((1 << eighty_twos_pkg::flag_cy) |
                                        (1 << eighty_twos_pkg::flag_p)  |
                                        (1 << eighty_twos_pkg::flag_z)  |
                                        (1 << eighty_twos_pkg::flag_s));

  logic [7:0] regs [0:6];  // B C D E H L, A in slot 6

  // Register code to storage slot
  function automatic logic [2:0] slot(input logic [2:0] code);
    return (code == eighty_twos_pkg::reg_a) ? 3'd6 : code;
  endfunction

  assign read_data = (read_addr == eighty_twos_pkg::reg_none) ? 8'h00 : regs[slot(read_addr)];
  assign acc       = regs[6];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < 7; i++) begin
        regs[i] <= 8'h00;
      end
      flags <= 8'h00;
    end else begin
      if (load_done) begin
        regs[6] <= load_data;  // LDA target is always A
      end else if (exec && write_en_req && write_addr != eighty_twos_pkg::reg_none) begin
        regs[slot(write_addr)] <= write_data;
      end
      if (exec && flag_write_req) begin
        flags <= new_flags & flag_mask;
      end
    end
  end

  a_load_not_exec: assert property (@(posedge clk) disable iff (!rst_n)
    !(load_done && exec));

endmodule

/* logic/alu.sv */
`timescale 1ns/10ps
module alu (
  input  eighty_twos_pkg::alu_op_e op,
  input  logic [7:0]               a,
  input  logic [7:0]               b,
  input  logic [7:0]               immediate,
  input  logic                     use_imm,
  input  logic                     pass_src,
  input  logic [7:0]               flags,
  input  eighty_twos_pkg::cond_e   cond,
  input  logic                     uncond,
  output logic [7:0]               result,
  output logic [7:0]               new_flags,
  output logic                     jump_taken
);

  logic [7:0] operand;
  logic [8:0] wide;  // Bit 8 is carry or borrow
  logic       carry_in;
  logic       cond_hit;

  assign operand  = use_imm ? immediate : b;
  assign carry_in = flags[eighty_twos_pkg::flag_cy];

  always_comb begin
    wide = {1'b0, operand};  // MOV and MVI pass the source through
    if (!pass_src) begin
      case (op)
        eighty_twos_pkg::alu_add: wide = {1'b0, a} + {1'b0, operand};
        eighty_twos_pkg::alu_adc: wide = {1'b0, a} + {1'b0, operand} + {8'd0, carry_in};
        eighty_twos_pkg::alu_sub: wide = {1'b0, a} - {1'b0, operand};
        eighty_twos_pkg::alu_sbb: wide = {1'b0, a} - {1'b0, operand} - {8'd0, carry_in};
        eighty_twos_pkg::alu_ana: wide = {1'b0, a & operand};  // Logic ops clear CY
        eighty_twos_pkg::alu_xra: wide = {1'b0, a ^ operand};
        eighty_twos_pkg::alu_ora: wide = {1'b0, a | operand};
        default:                  wide = {1'b0, a} - {1'b0, operand};  // CMP
      endcase
    end
  end

  assign result = wide[7:0];

  always_comb begin
    new_flags                          = 8'h00;
    new_flags[eighty_twos_pkg::flag_s]  = result[7];
    new_flags[eighty_twos_pkg::flag_z]  = (result == 8'h00);
    new_flags[eighty_twos_pkg::flag_p]  = ~^result;  // Even parity
    new_flags[eighty_twos_pkg::flag_cy] = wide[8];
  end

  always_comb begin
    case (cond)
      eighty_twos_pkg::cond_nz: cond_hit = !flags[eighty_twos_pkg::flag_z];
      eighty_twos_pkg::cond_z:  cond_hit = flags[eighty_twos_pkg::flag_z];
      eighty_twos_pkg::cond_nc: cond_hit = !flags[eighty_twos_pkg::flag_cy];
      eighty_twos_pkg::cond_c:  cond_hit = flags[eighty_twos_pkg::flag_cy];
      eighty_twos_pkg::cond_po: cond_hit = !flags[eighty_twos_pkg::flag_p];
      eighty_twos_pkg::cond_pe: cond_hit = flags[eighty_twos_pkg::flag_p];
      eighty_twos_pkg::cond_p:  cond_hit = !flags[eighty_twos_pkg::flag_s];
      default:                  cond_hit = flags[eighty_twos_pkg::flag_s];  // Minus
    endcase
  end

  assign jump_taken = uncond || cond_hit;

endmodule

/* logic/eighty_twos_pkg.sv */
package eighty_twos_pkg;

  // First instruction byte, register view
  typedef struct packed {
    logic [1:0] cls;
    logic [2:0] dst;
    logic [2:0] src;
  } reg_view_t;

  // First instruction byte, operation view
  typedef struct packed {
    logic [1:0] cls;
    logic [2:0] func;  // ALU op or jump condition
    logic [2:0] kind;  // Selects immediate, jump or direct form
  } op_view_t;

  typedef union packed {
    reg_view_t reg_v;
    op_view_t  op_v;
  } opcode_byte_u;

  localparam logic [1:0] cls_misc = 2'b00;
  localparam logic [1:0] cls_mov  = 2'b01;
  localparam logic [1:0] cls_alu  = 2'b10;
  localparam logic [1:0] cls_imm  = 2'b11;

  localparam logic [2:0] kind_imm = 3'b110;  // MVI and ALU immediate
  localparam logic [2:0] kind_jcc = 3'b010;  // Conditional jump, LDA, STA

  localparam logic [2:0] reg_b    = 3'd0;
  localparam logic [2:0] reg_c    = 3'd1;
  localparam logic [2:0] reg_d    = 3'd2;
  localparam logic [2:0] reg_e    = 3'd3;
  localparam logic [2:0] reg_h    = 3'd4;
  localparam logic [2:0] reg_l    = 3'd5;
  localparam logic [2:0] reg_none = 3'd6;  // Memory operand slot, not present
  localparam logic [2:0] reg_a    = 3'd7;

  localparam logic [7:0] op_hlt = 8'h76;
  localparam logic [7:0] op_sta = 8'h32;
  localparam logic [7:0] op_lda = 8'h3a;
  localparam logic [7:0] op_jmp = 8'hc3;

  typedef enum logic [2:0] {
    alu_add, alu_adc, alu_sub, alu_sbb, alu_ana, alu_xra, alu_ora, alu_cmp
  } alu_op_e;

  typedef enum logic [2:0] {
    cond_nz, cond_z, cond_nc, cond_c, cond_po, cond_pe, cond_p, cond_m
  } cond_e;

  localparam int flag_cy = 0;
  localparam int flag_p  = 2;
  localparam int flag_z  = 6;
  localparam int flag_s  = 7;

endpackage
